/* src.f */
+incdir+verification
rtl/cuPkg.sv
rtl/cuIfs.sv
rtl/opcodeDecoder.sv
rtl/microSequencer.sv
rtl/controlOutputStage.sv
rtl/controlUnit.sv
verification/tbControlUnit.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" \
    && verilator --binary --top-module tbControlUnit -f src.f -o simControlUnit \
    && ./obj_dir/simControlUnit | tee /dev/stderr | grep -q "All tests passed" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* verification/cuModel.svh */
`ifndef CU_MODEL_SVH
`define CU_MODEL_SVH

// Expected sequencer state, advanced once per rising edge
phaseT      mPhase;
int         mStep;
logic [7:0] mOp;
ctrlWordT   mCtrl;
aluFnT      mFn;

function automatic ctrlWordT bitOf(input int pos);
    return ctrlWordT'(1) << pos;
endfunction

function automatic int fnIndexOf(input logic [7:0] op);
    case (op)
        opAdd:        return 1;
        opSub:        return 2;
        opMul:        return 3;
        opDiv:        return 4;
        opAnd:        return 5;
        opOr:         return 6;
        opAndNot:     return 7;
        opShiftRight: return 8;
        opShiftLeft:  return 9;
        opNotAcc:     return 10;
        default:      return 0;
    endcase
endfunction

task automatic modelReset();
    mPhase = start;
    mStep  = 0;
    mOp    = 8'd0;
    mCtrl  = '0;
    mFn    = '0;
endtask

// One run cycle, by instruction and step
task automatic runStep(input logic flagNow, output ctrlWordT w, output logic done,
                       output logic setFn, output logic toStop);
    w      = '0;
    done   = 1'b0;
    setFn  = 1'b0;
    toStop = 1'b0;
    case (mOp)
        opXToPc:
        begin
            w    = bitOf(xToPc);
            done = 1'b1;
        end
        opHalt: toStop = 1'b1;
        opAccToX:
        begin
            case (mStep)
                1: w = bitOf(irToMar);
                2: w = bitOf(accToMdr);
                3: w = bitOf(memWrite);
                default: ;
            endcase
            done = (mStep == 3);
        end
        opXToAcc:
        begin
            case (mStep)
                1: w = bitOf(irToMar);
                2: w = bitOf(memRead) | bitOf(mdrLoad);
                3: w = bitOf(mdrToAcc);
                default: ;
            endcase
            done = (mStep == 3);
        end
        opAdd, opSub, opMul, opDiv, opAnd, opOr, opAndNot:
        begin
            case (mStep)
                1: w = bitOf(irToMar);
                2: w = bitOf(memRead) | bitOf(mdrLoad);
                3: w = bitOf(aluLoadB);
                4: w = bitOf(aluRun) | bitOf(aluToBus)
                       | ((mOp == opDiv) ? ctrlWordT'(0) : bitOf(accLoad));
                5: w = bitOf(accLoad);
                default: ;
            endcase
            setFn = (mStep == 4);
            done  = (mStep == ((mOp == opDiv) ? 5 : 4));
        end
        opShiftRight, opShiftLeft, opNotAcc:
        begin
            if (mStep == 1)
                w = bitOf(aluRun) | bitOf(accLoad);
            setFn = (mStep == 1);
            done  = (mStep == 1);
        end
        opClearIfFlag:
        begin
            // Taken branch adds one empty step
            if (mStep == 1 && flagNow)
                w = bitOf(xToPc);
            done = (mStep == 1 && !flagNow) || (mStep == 2);
        end
        default: done = 1'b1;
    endcase
endtask

task automatic modelStep(input logic flagNow, input logic [7:0] opNow);
    ctrlWordT w;
    phaseT    nextPhase;
    logic     done;
    logic     setFn;
    logic     toStop;
    w         = '0;
    nextPhase = mPhase;
    done      = 1'b0;
    setFn     = 1'b0;
    toStop    = 1'b0;
    case (mPhase)
        start:
        begin
            w         = bitOf(pcToMar);
            nextPhase = fetch;
        end
        fetch:
        begin
            w         = bitOf(memRead) | bitOf(mdrLoad) | bitOf(marLoad);
            nextPhase = opcodeFetch;
        end
        opcodeFetch:
        begin
            w         = bitOf(pcIncrement);
            nextPhase = opcodeRead;
        end
        opcodeRead:
        begin
            w         = bitOf(irLoad);
            nextPhase = run;
        end
        run:
        begin
            runStep(flagNow, w, done, setFn, toStop);
            if (done)
                nextPhase = start;
            else if (toStop)
                nextPhase = stop;
        end
        default: ;
    endcase
    // Cleared when leaving start
    if (mPhase == start)
        mFn = '0;
    else if (setFn)
        mFn = mFn | (aluFnT'(1) << fnIndexOf(mOp));
    if (mPhase == opcodeRead)
        mOp = opNow;
    mStep  = (mPhase == run && nextPhase == run) ? mStep + 1 : 0;
    mCtrl  = w;
    mPhase = nextPhase;
endtask

`endif

/* verification/tbControlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module tbControlUnit
    import cuPkg::*;
();

    localparam int instrCount = 300;
    localparam int cycleLimit = instrCount * 10 + 100;
    localparam int stopCycles = 20;

    logic        clk;
    logic        rst;
    logic        flag;
    logic [7:0]  opcodeIn;
    logic [15:0] ctrl;
    logic [10:0] fn;
    logic [5:0]  phase;

    logic [15:0] lfsr;
    int          cycles;
    int          issued;

    `include "cuModel.svh"

    controlUnit dut0
    (
        .clk      (clk),
        .rst      (rst),
        .flag     (flag),
        .opcodeIn (opcodeIn),
        .ctrl     (ctrl),
        .fn       (fn),
        .phase    (phase)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic lfsrBit();
        logic outBit;
        outBit = lfsr[0];
        lfsr   = {1'b0, lfsr[15:1]} ^ (outBit ? 16'hB400 : 16'h0000);
        return outBit;
    endfunction

    function automatic logic [7:0] drawBits(input int count);
        logic [7:0] bits;
        int         i;
        bits = '0;
        for (i = 0; i < count; i++)
        begin
            bits = {bits[6:0], lfsrBit()};
        end
        return bits;
    endfunction

    // 0 to 31, halt kept for the end
    function automatic logic [7:0] nextOpcode();
        logic [7:0] op;
        op = drawBits(5);
        while (op == opHalt)
        begin
            op = drawBits(5);
        end
        return op;
    endfunction

    task automatic failRun(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkCtrl(input ctrlWordT got, input ctrlWordT exp);
        if (got !== exp)
            failRun($sformatf("FAILED at %0t: ctrl is %h, expected %h", $time, got, exp));
    endtask

    task automatic checkFn(input aluFnT got, input aluFnT exp);
        if (got !== exp)
            failRun($sformatf("FAILED at %0t: fn is %b, expected %b", $time, got, exp));
    endtask

    task automatic checkPhase(input phaseT got, input phaseT exp);
        if (got !== exp)
            failRun($sformatf("FAILED at %0t: phase is %b, expected %b", $time, got, exp));
    endtask

    // Model steps with the DUT, outputs compared mid-cycle
    task automatic advanceCycle();
        @(posedge clk);
        modelStep(flag, opcodeIn);
        @(negedge clk);
        checkCtrl(ctrl, mCtrl);
        checkFn(fn, mFn);
        checkPhase(phaseT'(phase), mPhase);
    endtask

    always @(posedge clk)
    begin
        if (rst)
        begin
            cycles = cycles + 1;
            if (cycles > cycleLimit)
                failRun($sformatf("Timeout: halt not reached within %0d cycles", cycleLimit));
        end
    end

    initial
    begin
        rst      = 1'b0;
        flag     = 1'b0;
        opcodeIn = 8'd0;
        lfsr     = 16'd34;
        cycles   = 0;
        issued   = 0;
        modelReset();
        repeat (16) @(negedge clk);
        rst = 1'b1;
        checkCtrl(ctrl, '0);
        checkFn(fn, '0);
        checkPhase(phaseT'(phase), start);

        while (issued <= instrCount || mPhase != stop)
        begin
            advanceCycle();
            flag = lfsrBit();
            // Sampled at the end of opcodeRead
            if (mPhase == opcodeRead)
            begin
                if (issued < instrCount)
                    opcodeIn = nextOpcode();
                else
                    opcodeIn = opHalt;
                issued++;
            end
        end

        // Held in stop after halt
        repeat (stopCycles)
        begin
            advanceCycle();
            checkPhase(phaseT'(phase), stop);
            checkCtrl(ctrl, '0);
            flag = lfsrBit();
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit
    import cuPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flag,
    input  logic [7:0]  opcodeIn,
    output logic [15:0] ctrl,
    output logic [10:0] fn,
    output logic [5:0]  phase
);

    decodeIf decBus ();
    issueIf  issBus ();

    opcodeDecoder decoder0
    (
        .clk      (clk),
        .rst      (rst),
        .opcodeIn (opcodeT'(opcodeIn)),
        .dec      (decBus)
    );

    microSequencer sequencer0
    (
        .clk   (clk),
        .rst   (rst),
        .flag  (flag),
        .dec   (decBus),
        .iss   (issBus),
        .phase (phase)
    );

    controlOutputStage outStage0
    (
        .clk  (clk),
        .rst  (rst),
        .iss  (issBus),
        .ctrl (ctrl),
        .fn   (fn)
    );

endmodule

`default_nettype wire

/* rtl/controlOutputStage.sv */
`timescale 1ns/1ps
`default_nettype none

module controlOutputStage
    import cuPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    issueIf.outStage  iss,
    output ctrlWordT  ctrl,
    output aluFnT     fn
);

    // Word of the state being left, visible for one cycle
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ctrl <= '0;
        end
        else
        begin
            ctrl <= iss.ctrlNext;
        end
    end

    // Function flags accumulate until the next start
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            fn <= '0;
        end
        else if (iss.fnClear)
        begin
            fn <= '0;
        end
        else if (iss.fnSet)
        begin
            fn <= fn | (aluFnT'(1) << iss.fnIdx);
        end
    end

endmodule

`default_nettype wire

/* rtl/microSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module microSequencer
    import cuPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flag,
    decodeIf.sequencer dec,
    issueIf.sequencer  iss,
    output phaseT      phase
);

    phaseT    phaseNext;
    stepT     step;
    stepT     stepNext;
    ctrlWordT word;
    logic     lastStep;
    logic     aluStep;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            phase <= start;
            step  <= '0;
        end
        else
        begin
            phase <= phaseNext;
            step  <= stepNext;
        end
    end

    always_comb
    begin
        phaseNext = phase;
        stepNext  = step;
        word      = '0;
        lastStep  = 1'b0;
        aluStep   = 1'b0;
        case (phase)
            start:
            begin
                word[pcToMar] = 1'b1;
                phaseNext     = fetch;
            end
            fetch:
            begin
                word[memRead] = 1'b1;
                word[mdrLoad] = 1'b1;
                word[marLoad] = 1'b1;
                phaseNext     = opcodeFetch;
            end
            opcodeFetch:
            begin
                word[pcIncrement] = 1'b1;
                phaseNext         = opcodeRead;
            end
            opcodeRead:
            begin
                word[irLoad] = 1'b1;
                phaseNext    = run;
                stepNext     = '0;
            end
            run:
            begin
                stepNext = step + 3'd1;
                // Step 0 is the idle cycle for every routine but jump
                case (dec.routine)
                    jump:
                    begin
                        word[xToPc] = 1'b1;
                        lastStep    = 1'b1;
                    end
                    halt:
                    begin
                        phaseNext = stop;
                        stepNext  = '0;
                    end
                    unknown:
                    begin
                        lastStep = 1'b1;
                    end
                    toX:
                    begin
                        case (step)
                            3'd1: word[irToMar] = 1'b1;
                            3'd2: word[accToMdr] = 1'b1;
                            3'd3:
                            begin
                                word[memWrite] = 1'b1;
                                lastStep       = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    fromX:
                    begin
                        case (step)
                            3'd1: word[irToMar] = 1'b1;
                            3'd2:
                            begin
                                word[memRead] = 1'b1;
                                word[mdrLoad] = 1'b1;
                            end
                            3'd3:
                            begin
                                word[mdrToAcc] = 1'b1;
                                lastStep       = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    binary, divide:
                    begin
                        case (step)
                            3'd1: word[irToMar] = 1'b1;
                            3'd2:
                            begin
                                word[memRead] = 1'b1;
                                word[mdrLoad] = 1'b1;
                            end
                            3'd3: word[aluLoadB] = 1'b1;
                            3'd4:
                            begin
                                word[aluRun]   = 1'b1;
                                word[aluToBus] = 1'b1;
                                aluStep        = 1'b1;
                                // Divide loads the accumulator one step later
                                if (dec.routine == binary)
                                begin
                                    word[accLoad] = 1'b1;
                                    lastStep      = 1'b1;
                                end
                            end
                            3'd5:
                            begin
                                word[accLoad] = 1'b1;
                                lastStep      = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    unary:
                    begin
                        if (step == 3'd1)
                        begin
                            word[aluRun]  = 1'b1;
                            word[accLoad] = 1'b1;
                            aluStep       = 1'b1;
                            lastStep      = 1'b1;
                        end
                    end
                    clearIfFlag:
                    begin
                        if (step == 3'd1)
                        begin
                            if (flag)
                            begin
                                word[xToPc] = 1'b1;
                            end
                            else
                            begin
                                lastStep = 1'b1;
                            end
                        end
                        else if (step == 3'd2)
                        begin
                            lastStep = 1'b1;
                        end
                    end
                    default: lastStep = 1'b1;
                endcase
                if (lastStep)
                begin
                    phaseNext = start;
                    stepNext  = '0;
                end
            end
            // Held until reset
            stop: phaseNext = stop;
            default:
            begin
                phaseNext = start;
                stepNext  = '0;
            end
        endcase
    end

    assign dec.opcodeLoad = (phase == opcodeRead);

    assign iss.ctrlNext = word;
    assign iss.fnSet    = aluStep && dec.hasAluFn;
    assign iss.fnIdx    = dec.aluIdx;
    assign iss.fnClear  = (phase == start);

endmodule

`default_nettype wire

/* rtl/opcodeDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module opcodeDecoder
    import cuPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  opcodeT   opcodeIn,
    decodeIf.decoder dec
);

    opcodeT   opcode;
    aluFnIdxT aluIdx;

    // Captured at the end of opcodeRead
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            opcode <= opNone;
        end
        else if (dec.opcodeLoad)
        begin
            opcode <= opcodeIn;
        end
    end

    always_comb
    begin
        dec.routine = unknown;
        aluIdx      = '0;
        case (opcode)
            opNone:        dec.routine = unknown;
            opAccToX:      dec.routine = toX;
            opXToAcc:      dec.routine = fromX;
            opClearIfFlag: dec.routine = clearIfFlag;
            opXToPc:       dec.routine = jump;
            opHalt:        dec.routine = halt;
            opAdd:
            begin
                dec.routine = binary;
                aluIdx      = fnAdd;
            end
            opSub:
            begin
                dec.routine = binary;
                aluIdx      = fnSub;
            end
            opMul:
            begin
                dec.routine = binary;
                aluIdx      = fnMul;
            end
            opAnd:
            begin
                dec.routine = binary;
                aluIdx      = fnAnd;
            end
            opOr:
            begin
                dec.routine = binary;
                aluIdx      = fnOr;
            end
            opAndNot:
            begin
                dec.routine = binary;
                aluIdx      = fnAndNot;
            end
            opDiv:
            begin
                dec.routine = divide;
                aluIdx      = fnDiv;
            end
            opShiftRight:
            begin
                dec.routine = unary;
                aluIdx      = fnShiftRight;
            end
            opShiftLeft:
            begin
                dec.routine = unary;
                aluIdx      = fnShiftLeft;
            end
            opNotAcc:
            begin
                dec.routine = unary;
                aluIdx      = fnNotAcc;
            end
            // Out of range, idle cycle then back to fetch
            default:       dec.routine = unknown;
        endcase
    end

    assign dec.aluIdx   = aluIdx;
    assign dec.hasAluFn = (aluIdx != '0);

endmodule

`default_nettype wire

/* rtl/cuIfs.sv */
`timescale 1ns/1ps
`default_nettype none

// Decoded instruction from the opcode register to the sequencer
interface decodeIf
    import cuPkg::*;
();
    logic     opcodeLoad;
    routineT  routine;
    aluFnIdxT aluIdx;
    logic     hasAluFn;

    modport decoder (input opcodeLoad, output routine, output aluIdx, output hasAluFn);
    modport sequencer (output opcodeLoad, input routine, input aluIdx, input hasAluFn);
endinterface

// Next control word and flag updates toward the output registers
interface issueIf
    import cuPkg::*;
();
    ctrlWordT ctrlNext;
    logic     fnSet;
    aluFnIdxT fnIdx;
    logic     fnClear;

    modport sequencer (output ctrlNext, output fnSet, output fnIdx, output fnClear);
    modport outStage (input ctrlNext, input fnSet, input fnIdx, input fnClear);
endinterface

`default_nettype wire

/* rtl/cuPkg.sv */
`default_nettype none

package cuPkg;

    // Instruction opcodes, 16 to 255 are not defined
    typedef enum logic [7:0]
    {
        opNone        = 8'd0,
        opAccToX      = 8'd1,
        opXToAcc      = 8'd2,
        opAdd         = 8'd3,
        opSub         = 8'd4,
        opClearIfFlag = 8'd5,
        opXToPc       = 8'd6,
        opHalt        = 8'd7,
        opMul         = 8'd8,
        opDiv         = 8'd9,
        opAnd         = 8'd10,
        opOr          = 8'd11,
        opAndNot      = 8'd12,
        opShiftRight  = 8'd13,
        opShiftLeft   = 8'd14,
        opNotAcc      = 8'd15
    } opcodeT;

    typedef logic [15:0] ctrlWordT;

    // Datapath control lines, bit 1 has no function
    localparam int memRead     = 0;
    localparam int pcToMar     = 2;
    localparam int xToPc       = 3;
    localparam int pcIncrement = 4;
    localparam int mdrLoad     = 5;
    localparam int aluLoadB    = 6;
    localparam int aluRun      = 7;
    localparam int irToMar     = 8;
    localparam int accLoad     = 9;
    localparam int mdrToAcc    = 10;
    localparam int accToMdr    = 11;
    localparam int memWrite    = 12;
    localparam int irLoad      = 13;
    localparam int aluToBus    = 14;
    localparam int marLoad     = 15;

    // One flag per ALU function
    typedef logic [10:0] aluFnT;
    typedef logic [3:0]  aluFnIdxT;

    localparam aluFnIdxT fnAdd        = 4'd1;
    localparam aluFnIdxT fnSub        = 4'd2;
    localparam aluFnIdxT fnMul        = 4'd3;
    localparam aluFnIdxT fnDiv        = 4'd4;
    localparam aluFnIdxT fnAnd        = 4'd5;
    localparam aluFnIdxT fnOr         = 4'd6;
    localparam aluFnIdxT fnAndNot     = 4'd7;
    localparam aluFnIdxT fnShiftRight = 4'd8;
    localparam aluFnIdxT fnShiftLeft  = 4'd9;
    localparam aluFnIdxT fnNotAcc     = 4'd10;

    typedef enum logic [5:0]
    {
        start       = 6'b000001,
        fetch       = 6'b000010,
        opcodeFetch = 6'b000100,
        opcodeRead  = 6'b001000,
        run         = 6'b010000,
        stop        = 6'b100000
    } phaseT;

    // Micro-routine kinds, each with its own step list
    typedef enum logic [3:0]
    {
        toX,
        fromX,
        binary,
        divide,
        clearIfFlag,
        jump,
        halt,
        unary,
        unknown
    } routineT;

    typedef logic [2:0] stepT;

endpackage

`default_nettype wire
